/* tb.f */
+incdir+.
mem_layout_pkg.sv
window_pkg.sv
input_layer_if.sv
run_ctrl.sv
fetch_ctrl.sv
line_buffer.sv
window_seq.sv
input_layer_top.sv
input_layer_asserts.sv
tb_clock.sv
tb_input_layer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tb_input_layer
FILELIST = tb.f
OBJ_DIR = obj_dir
LOG = sim.log
RUN_FLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_input_layer.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module tb_input_layer;
	localparam int RUN_TIMEOUT = 5000;

	logic clk;
	logic reset;
	logic start;
	logic [`IL_ADDR_W-1:0] base_addr;
	logic [`IL_DIM_W-1:0] layers;
	logic [`IL_DIM_W-1:0] rows;
	logic [`IL_DIM_W-1:0] cols;
	logic ddr_ready;
	logic [`IL_ADDR_W-1:0] ar_addr;
	logic [7:0] ar_len;
	logic ar_valid;
	logic ar_ready = 1'b0;
	logic [`IL_DATA_W-1:0] r_data = '0;
	logic r_last = 1'b0;
	logic r_valid = 1'b0;
	logic r_ready;
	logic [`IL_WIN_W-1:0] window_data;
	logic [`IL_DIM_W-1:0] window_layer;
	logic window_valid;
	logic window_ready = 1'b0;
	logic busy;
	logic done;

	integer seed = 55;
	// current run, as the checkers see it
	logic [31:0] run_base = '0;
	int run_layers = 1;
	int run_rows = 3;
	int run_cols = 3;
	logic hold_ready = 1'b0;
	int ar_count = 0;
	int win_count = 0;
	int done_count = 0;
	// memory model burst state
	logic [31:0] burst_addr = '0;
	int beat = 0;
	logic burst_on = 1'b0;

	tb_clock u_clock (.clk(clk));

	input_layer_top uut (
		.clk(clk), .reset(reset), .start(start), .base_addr(base_addr),
		.layers(layers), .rows(rows), .cols(cols), .ddr_ready(ddr_ready),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready),
		.window_data(window_data), .window_layer(window_layer),
		.window_valid(window_valid), .window_ready(window_ready),
		.busy(busy), .done(done)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	// byte stored at address a: 7*block + 13*row + offset, low byte
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] v;
		v = 32'd7 * {12'd0, a[31:12]} + 32'd13 * {26'd0, a[11:6]} + {26'd0, a[5:0]};
		return v[7:0];
	endfunction

	// beat b of a burst, lane k holds the byte at the lower address
	function automatic logic [`IL_DATA_W-1:0] beat_data(input logic [31:0] a, input int b);
		logic [`IL_DATA_W-1:0] d;
		int off;
		for (int k = 0; k < 8; k++) begin
			off = (b / `IL_WORDS_PER_ROW) * `IL_ROW_BYTES + (b % `IL_WORDS_PER_ROW) * 8 + k;
			d[8*k +: 8] = mem_byte(a + 32'(off));
		end
		return d;
	endfunction

	// pixel (i, j) of the window at row set r, layer l, column c
	function automatic logic [`IL_WIN_W-1:0] expect_window(input int r, input int l, input int c);
		logic [`IL_WIN_W-1:0] w;
		logic [31:0] a;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				a = run_base + 32'(l * `IL_LAYER_BYTES + (r + i) * `IL_ROW_BYTES + c + j);
				w[8*(3*i+j) +: 8] = mem_byte(a);
			end
		end
		return w;
	endfunction

	// ------------------------------------------------------------
	// AXI read slave, gapped beats
	// ------------------------------------------------------------
	always @(negedge clk) begin : memory_model
		logic [31:0] exp_addr;
		ar_ready = ($random(seed) % 4) != 0;
		if (burst_on) begin
			r_valid = ($random(seed) % 3) != 0;
			r_data = beat_data(burst_addr, beat);
			r_last = (beat == `IL_BURST_BEATS - 1);
		end else begin
			r_valid = 1'b0;
			r_last = 1'b0;
		end
		#1;
		if (start) ar_count = 0;
		// layer runs inside row position
		if (ar_valid && ar_ready) begin
			exp_addr = run_base + 32'((ar_count % run_layers) * `IL_LAYER_BYTES
				+ (ar_count / run_layers) * `IL_ROW_BYTES);
			if (ar_addr !== exp_addr)
				report_mismatch($sformatf("burst %0d at %h, expected %h", ar_count, ar_addr, exp_addr));
			if (ar_len !== 8'(`IL_BURST_BEATS - 1))
				report_mismatch($sformatf("ar_len %0d, expected 23", ar_len));
			burst_addr = ar_addr;
			beat = 0;
			burst_on = 1'b1;
			ar_count++;
		end
		if (r_valid && r_ready) begin
			beat++;
			if (beat == `IL_BURST_BEATS) burst_on = 1'b0;
		end
	end

	// ------------------------------------------------------------
	// window sink and checker
	// ------------------------------------------------------------
	always @(negedge clk) begin : window_check
		int per_set;
		int total;
		int r;
		int l;
		int c;
		logic [`IL_WIN_W-1:0] exp_win;
		window_ready = hold_ready ? 1'b0 : (($random(seed) % 3) != 0);
		#1;
		if (start) begin
			win_count = 0;
			done_count = 0;
		end
		per_set = run_layers * (run_cols - 2);
		total = per_set * (run_rows - 2);
		if (window_valid && window_ready) begin
			r = win_count / per_set;
			l = (win_count % per_set) / (run_cols - 2);
			c = win_count % (run_cols - 2);
			exp_win = expect_window(r, l, c);
			if (window_data !== exp_win)
				report_mismatch($sformatf("window %0d is %h, expected %h", win_count, window_data, exp_win));
			if (window_layer !== `IL_DIM_W'(l))
				report_mismatch($sformatf("window %0d layer %0d, expected %0d", win_count, window_layer, l));
			win_count++;
		end
		if (done) begin
			done_count++;
			if (done_count != 1) report_mismatch("second done pulse in one run");
			if (win_count != total)
				report_mismatch($sformatf("done after %0d windows, expected %0d", win_count, total));
		end
		if (uut.u_asserts.fail_count != 0) begin
			$display("a protocol assertion on the DUT failed");
			abort_run();
		end
	end

	// ------------------------------------------------------------
	// one run from start to done
	// ------------------------------------------------------------
	task automatic run_job(input logic [31:0] base, input int nl, input int nr, input int nc,
			input bit stall);
		int cycles;
		@(negedge clk);
		run_base = base;
		run_layers = nl;
		run_rows = nr;
		run_cols = nc;
		base_addr = base;
		layers = `IL_DIM_W'(nl);
		rows = `IL_DIM_W'(nr);
		cols = `IL_DIM_W'(nc);
		start = 1'b1;
		ddr_ready = !stall;
		hold_ready = stall;
		@(negedge clk);
		start = 1'b0;
		if (stall) begin
			// memory not ready yet, nothing may be requested
			repeat (40) @(negedge clk);
			if (ar_count != 0) report_mismatch("burst issued while ddr_ready low");
			ddr_ready = 1'b1;
			// sink stalled, both banks fill and fetch stops
			repeat (300) @(negedge clk);
			if (ar_count != 2)
				report_mismatch($sformatf("%0d bursts under back-pressure, expected 2", ar_count));
			hold_ready = 1'b0;
		end
		cycles = 0;
		while (done_count == 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				$display("timeout: run did not finish, %0d windows seen", win_count);
				abort_run();
			end
		end
		// idle stretch, no further windows or done
		repeat (20) @(negedge clk);
		if (ar_count != nl * (nr - 2))
			report_mismatch($sformatf("%0d bursts in run, expected %0d", ar_count, nl * (nr - 2)));
		if (busy !== 1'b0) report_mismatch("busy still high after done");
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		base_addr = '0;
		layers = '0;
		rows = '0;
		cols = '0;
		ddr_ready = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		run_job(32'h0001_0000, 2, 5, 6, 1'b1);
		run_job(32'h0004_3000, 1, 3, 64, 1'b0);
		if (uut.u_asserts.fail_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("protocol assertions failed %0d times", uut.u_asserts.fail_count);
			abort_run();
		end
	end
endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

// free running testbench clock
module tb_clock #(
	parameter int HALF_PERIOD = 20
) (
	output logic clk
);
	// 40 ns period, starts low
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end
endmodule

/* input_layer_asserts.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module input_layer_asserts (
	input logic clk,
	input logic reset,
	input logic ddr_ready,
	input logic [`IL_ADDR_W-1:0] ar_addr,
	input logic ar_valid,
	input logic ar_ready,
	input logic r_ready,
	input logic [`IL_WIN_W-1:0] window_data,
	input logic [`IL_DIM_W-1:0] window_layer,
	input logic window_valid,
	input logic window_ready,
	input logic busy,
	input logic done
);
	// failed checks so far, polled by the testbench top
	int fail_count = 0;

	// ------------------------------------------------------------
	// AXI read address channel
	// ------------------------------------------------------------
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else begin
			$error("ar_valid dropped or address changed before ar_ready");
			fail_count = fail_count + 1;
		end

	// request only after memory reported ready
	ar_gate: assert property (@(posedge clk) disable iff (reset)
		$rose(ar_valid) |-> $past(ddr_ready))
		else begin
			$error("ar_valid rose while ddr_ready was low");
			fail_count = fail_count + 1;
		end

	// ------------------------------------------------------------
	// window stream
	// ------------------------------------------------------------
	win_hold: assert property (@(posedge clk) disable iff (reset)
		window_valid && !window_ready |=>
		window_valid && $stable(window_data) && $stable(window_layer))
		else begin
			$error("window changed or dropped while stalled");
			fail_count = fail_count + 1;
		end

	// done is a single cycle and takes busy down with it
	done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done && !busy)
		else begin
			$error("done longer than one cycle or busy still high");
			fail_count = fail_count + 1;
		end

	// no bank left full once the final window is gone
	done_drained: assert property (@(posedge clk) disable iff (reset)
		done |-> !window_valid)
		else begin
			$error("window_valid still high in the done cycle");
			fail_count = fail_count + 1;
		end

	// outputs quiet through reset and the cycle after it
	reset_state: assert property (@(posedge clk)
		reset |=> !ar_valid && !r_ready && !window_valid && !busy && !done)
		else begin
			$error("output active during or right after reset");
			fail_count = fail_count + 1;
		end
endmodule

bind input_layer_top input_layer_asserts u_asserts (
	.clk(clk), .reset(reset), .ddr_ready(ddr_ready),
	.ar_addr(ar_addr), .ar_valid(ar_valid), .ar_ready(ar_ready),
	.r_ready(r_ready), .window_data(window_data), .window_layer(window_layer),
	.window_valid(window_valid), .window_ready(window_ready),
	.busy(busy), .done(done)
);

/* input_layer_top.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module input_layer_top (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`IL_ADDR_W-1:0] base_addr,
	input logic [`IL_DIM_W-1:0] layers,
	input logic [`IL_DIM_W-1:0] rows,
	input logic [`IL_DIM_W-1:0] cols,
	input logic ddr_ready,
	output logic [`IL_ADDR_W-1:0] ar_addr,
	output logic [7:0] ar_len,
	output logic ar_valid,
	input logic ar_ready,
	input logic [`IL_DATA_W-1:0] r_data,
	input logic r_last,
	input logic r_valid,
	output logic r_ready,
	output logic [`IL_WIN_W-1:0] window_data,
	output logic [`IL_DIM_W-1:0] window_layer,
	output logic window_valid,
	input logic window_ready,
	output logic busy,
	output logic done
);
	import window_pkg::*;

	logic [1:0] bank_full;
	logic bank_release;
	logic rd_bank;
	logic [5:0] rd_col;
	window_u window;

	run_cfg_if cfg ();
	line_wr_if lw ();

	assign busy = cfg.busy;
	assign window_data = window.flat;

	// ------------------------------------------------------------
	// run control, fetch, buffer, sequencer
	// ------------------------------------------------------------
	run_ctrl u_run_ctrl (
		.clk(clk), .reset(reset), .start(start), .base_addr(base_addr),
		.layers(layers), .rows(rows), .cols(cols), .done(done), .cfg(cfg)
	);

	fetch_ctrl u_fetch_ctrl (
		.clk(clk), .reset(reset), .cfg(cfg), .ddr_ready(ddr_ready),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready),
		.wr(lw), .bank_full(bank_full), .bank_release(bank_release)
	);

	line_buffer u_line_buffer (
		.clk(clk), .wr(lw), .rd_bank(rd_bank), .rd_col(rd_col), .window(window)
	);

	window_seq u_window_seq (
		.clk(clk), .reset(reset), .cfg(cfg), .bank_full(bank_full),
		.bank_release(bank_release), .rd_bank(rd_bank), .rd_col(rd_col),
		.window_layer(window_layer), .window_valid(window_valid),
		.window_ready(window_ready), .done(done)
	);
endmodule

/* window_seq.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module window_seq (
	input logic clk,
	input logic reset,
	run_cfg_if.dst cfg,
	input logic [1:0] bank_full,
	output logic bank_release,
	output logic rd_bank,
	output logic [5:0] rd_col,
	output logic [`IL_DIM_W-1:0] window_layer,
	output logic window_valid,
	input logic window_ready,
	output logic done
);
	import window_pkg::*;

	logic [`IL_DIM_W-1:0] col;
	logic [`IL_DIM_W-1:0] layer;
	logic [`IL_DIM_W-1:0] rpos;
	logic fire;
	logic last_col;
	logic last_layer;
	logic last_rpos;

	// ------------------------------------------------------------
	// stream handshake
	// ------------------------------------------------------------
	assign window_valid = cfg.busy & bank_full[rd_bank];
	assign fire = window_valid & window_ready;

	assign last_col = (col == cfg.cols - `IL_DIM_W'(WIN_SPAN + 1));
	assign last_layer = (layer == cfg.layers - `IL_DIM_W'(1));
	assign last_rpos = (rpos == cfg.rows - `IL_DIM_W'(WIN_SPAN + 1));

	// bank is finished after its last column
	assign bank_release = fire & last_col;

	assign rd_col = col[5:0];
	assign window_layer = layer;

	// ------------------------------------------------------------
	// stream order: column inside layer inside row position
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset | cfg.start) begin
			col <= '0;
			layer <= '0;
			rpos <= '0;
			rd_bank <= 1'b0;
		end else if (fire) begin
			if (last_col) begin
				col <= '0;
				rd_bank <= ~rd_bank;
				if (last_layer) begin
					layer <= '0;
					rpos <= rpos + `IL_DIM_W'(1);
				end else begin
					layer <= layer + `IL_DIM_W'(1);
				end
			end else begin
				col <= col + `IL_DIM_W'(1);
			end
		end
	end

	// one cycle after the final window
	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= bank_release & last_layer & last_rpos;
		end
	end
endmodule

/* line_buffer.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module line_buffer (
	input logic clk,
	line_wr_if.rd wr,
	input logic rd_bank,
	input logic [5:0] rd_col,
	output window_pkg::window_u window
);
	import window_pkg::*;

	localparam int ROW_BITS = `IL_MAX_COLS * `IL_PIXEL_W;

	// two banks of three rows, eight words per row
	logic [`IL_DATA_W-1:0] mem [2][WIN_ROWS][`IL_WORDS_PER_ROW];
	logic [ROW_BITS-1:0] row_bits [WIN_ROWS];

	always_ff @(posedge clk) begin
		if (wr.wr_en) begin
			mem[wr.wr_bank][wr.wr_row][wr.wr_word] <= wr.wr_data;
		end
	end

	// byte lane k of word w is column 8w+k
	always_comb begin
		for (int i = 0; i < WIN_ROWS; i++) begin
			for (int w = 0; w < `IL_WORDS_PER_ROW; w++) begin
				row_bits[i][w*`IL_DATA_W +: `IL_DATA_W] = mem[rd_bank][i][w];
			end
		end
		// columns rd_col..rd_col+2 of each row
		for (int i = 0; i < WIN_ROWS; i++) begin
			for (int j = 0; j < WIN_COLS; j++) begin
				window.pix[i][j] = row_bits[i][(32'(rd_col) + j)*`IL_PIXEL_W +: `IL_PIXEL_W];
			end
		end
	end
endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module fetch_ctrl (
	input logic clk,
	input logic reset,
	run_cfg_if.dst cfg,
	input logic ddr_ready,
	output logic [`IL_ADDR_W-1:0] ar_addr,
	output logic [7:0] ar_len,
	output logic ar_valid,
	input logic ar_ready,
	input logic [`IL_DATA_W-1:0] r_data,
	input logic r_last,
	input logic r_valid,
	output logic r_ready,
	line_wr_if.wr wr,
	output logic [1:0] bank_full,
	input logic bank_release
);
	import mem_layout_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ADDR = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam int WORD_W = $clog2(`IL_WORDS_PER_ROW);

	logic [1:0] state;
	logic [`IL_DIM_W-1:0] f_row;
	logic [`IL_DIM_W-1:0] f_layer;
	logic all_issued;
	logic wr_bank;
	logic rel_bank;
	logic [1:0] row_cnt;
	logic [WORD_W-1:0] word_cnt;
	logic ar_fire;
	logic r_fire;
	logic last_beat;
	logic can_issue;
	burst_addr_u addr;

	// ------------------------------------------------------------
	// burst address from row position and layer
	// ------------------------------------------------------------
	always_comb begin
		addr.f.block = cfg.base_addr[`IL_ADDR_W-1 -: BLOCK_W] + BLOCK_W'(f_layer);
		addr.f.row = f_row[ROW_W-1:0];
		addr.f.offset = '0;
	end

	assign ar_addr = addr.flat;
	assign ar_len = 8'(`IL_BURST_BEATS - 1);
	assign ar_valid = (state == S_ADDR);
	assign r_ready = (state == S_DATA);

	assign ar_fire = ar_valid & ar_ready;
	assign r_fire = r_valid & r_ready;
	assign last_beat = r_fire & r_last;
	// free fill bank, work left, memory up
	assign can_issue = cfg.busy & ~all_issued & ddr_ready & ~bank_full[wr_bank];

	always_ff @(posedge clk) begin
		if (reset | cfg.start) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (can_issue) state <= S_ADDR;
				S_ADDR: if (ar_fire) state <= S_DATA;
				S_DATA: if (last_beat) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// fetch order: layer inside row position
	always_ff @(posedge clk) begin
		if (reset | cfg.start) begin
			f_row <= '0;
			f_layer <= '0;
			all_issued <= 1'b0;
		end else if (ar_fire) begin
			if (f_layer == cfg.layers - `IL_DIM_W'(1)) begin
				f_layer <= '0;
				if (f_row == cfg.rows - `IL_DIM_W'(3)) begin
					all_issued <= 1'b1;
				end else begin
					f_row <= f_row + `IL_DIM_W'(1);
				end
			end else begin
				f_layer <= f_layer + `IL_DIM_W'(1);
			end
		end
	end

	// ------------------------------------------------------------
	// beat position inside the bank
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset | ar_fire) begin
			row_cnt <= '0;
			word_cnt <= '0;
		end else if (r_fire) begin
			word_cnt <= word_cnt + WORD_W'(1);
			if (word_cnt == WORD_W'(`IL_WORDS_PER_ROW - 1)) begin
				row_cnt <= row_cnt + 2'd1;
			end
		end
	end

	assign wr.wr_en = r_fire;
	assign wr.wr_bank = wr_bank;
	assign wr.wr_row = row_cnt;
	assign wr.wr_word = word_cnt;
	assign wr.wr_data = r_data;

	// ------------------------------------------------------------
	// bank ownership
	// ------------------------------------------------------------
	// banks are filled and released in the same alternating order
	always_ff @(posedge clk) begin
		if (reset | cfg.start) begin
			bank_full <= 2'b00;
			wr_bank <= 1'b0;
			rel_bank <= 1'b0;
		end else begin
			if (last_beat) begin
				bank_full[wr_bank] <= 1'b1;
				wr_bank <= ~wr_bank;
			end
			// oldest full bank goes back to the fetch side
			if (bank_release) begin
				bank_full[rel_bank] <= 1'b0;
				rel_bank <= ~rel_bank;
			end
		end
	end
endmodule

/* run_ctrl.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

module run_ctrl (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [`IL_ADDR_W-1:0] base_addr,
	input logic [`IL_DIM_W-1:0] layers,
	input logic [`IL_DIM_W-1:0] rows,
	input logic [`IL_DIM_W-1:0] cols,
	input logic done,
	run_cfg_if.src cfg
);
	logic accept;

	// start while a run is active is dropped
	assign accept = start & ~cfg.busy;
	assign cfg.start = accept;

	// busy from the cycle after start until the done cycle ends
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.busy <= 1'b0;
		end else if (accept) begin
			cfg.busy <= 1'b1;
		end else if (done) begin
			cfg.busy <= 1'b0;
		end
	end

	// run parameters
	always_ff @(posedge clk) begin
		if (accept) begin
			cfg.base_addr <= base_addr;
			cfg.layers <= layers;
			cfg.rows <= rows;
			cfg.cols <= cols;
		end
	end
endmodule

/* input_layer_if.sv */
`timescale 1ns/1ps
`include "input_layer_config.svh"

// run parameters, latched once per run
interface run_cfg_if;
	// accepted start pulse, clears the sequencers
	logic start;
	logic busy;
	logic [`IL_ADDR_W-1:0] base_addr;
	logic [`IL_DIM_W-1:0] layers;
	logic [`IL_DIM_W-1:0] rows;
	logic [`IL_DIM_W-1:0] cols;

	modport src (output start, busy, base_addr, layers, rows, cols);
	modport dst (input start, busy, base_addr, layers, rows, cols);
endinterface

// one 64-bit word into the line buffer
interface line_wr_if;
	logic wr_en;
	logic wr_bank;
	// row within the three row set
	logic [1:0] wr_row;
	// word within a 64 byte row
	logic [$clog2(`IL_WORDS_PER_ROW)-1:0] wr_word;
	logic [`IL_DATA_W-1:0] wr_data;

	modport wr (output wr_en, wr_bank, wr_row, wr_word, wr_data);
	modport rd (input wr_en, wr_bank, wr_row, wr_word, wr_data);
endinterface

/* window_pkg.sv */
`include "input_layer_config.svh"

package window_pkg;
	// window geometry
	localparam int WIN_ROWS = 3;
	localparam int WIN_COLS = 3;

	// flat stream word, or nine pixels by row and column
	// pix[i][j] sits at bits 8*(3i+j) upward
	typedef union packed {
		logic [`IL_WIN_W-1:0] flat;
		logic [WIN_ROWS-1:0][WIN_COLS-1:0][`IL_PIXEL_W-1:0] pix;
	} window_u;

	// offset of the last window column from the first
	localparam int WIN_SPAN = WIN_COLS - 1;

endpackage

/* mem_layout_pkg.sv */
`include "input_layer_config.svh"

package mem_layout_pkg;
	// field widths of a burst start address
	localparam int OFFSET_W = $clog2(`IL_ROW_BYTES);
	localparam int ROW_W = $clog2(`IL_LAYER_BYTES / `IL_ROW_BYTES);
	localparam int BLOCK_W = `IL_ADDR_W - OFFSET_W - ROW_W;

	// flat AXI address, or split into layer block, row and byte offset
	// block = 4k aligned base plus layer index
	typedef union packed {
		logic [`IL_ADDR_W-1:0] flat;
		struct packed {
			logic [BLOCK_W-1:0] block;
			logic [ROW_W-1:0] row;
			logic [OFFSET_W-1:0] offset;
		} f;
	} burst_addr_u;
endpackage

/* input_layer_config.svh */
`ifndef INPUT_LAYER_CONFIG_SVH
`define INPUT_LAYER_CONFIG_SVH

// bus and counter widths
`define IL_ADDR_W 32
`define IL_DATA_W 64
`define IL_DIM_W 10
`define IL_PIXEL_W 8

// external memory layout, one byte per pixel
`define IL_ROW_BYTES 64
`define IL_LAYER_BYTES 4096

// one burst carries three rows of eight words each
`define IL_BURST_BEATS 24
`define IL_WORDS_PER_ROW 8

// 3x3 window of pixels, widest supported row
`define IL_WIN_W 72
`define IL_MAX_COLS 64
`endif
